//--- project.f
source/mac_table_pkg.sv
source/table_ram.sv
source/lookup_pipe.sv
source/learn_queue.sv
source/gc_engine.sv
source/table_port_arbiter.sv
source/mac_table.sv
bench/tb_clock.sv
bench/tb_mac_table.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --timing --top-module tb_mac_table -f project.f
	./obj_dir/Vtb_mac_table | tee /dev/stderr | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

//--- bench/tb_mac_table.sv
`timescale 1ns/1ps

module tb_mac_table
	import mac_table_pkg::*;
;
	localparam int TABLE_ROWS   = 16;
	localparam int ASSOC_WAYS   = 4;
	localparam int PENDING_SIZE = 4;
	localparam int LATENCY      = 3;
	localparam int SPACING      = 12;
	localparam int NUM_LOOKUPS  = 36;
	localparam int NUM_GC       = 5;
	localparam int GC_LIMIT     = ASSOC_WAYS * TABLE_ROWS * 8;
	localparam int LIMIT        = 8 + 20 + NUM_LOOKUPS * SPACING + NUM_GC * GC_LIMIT + 200;

	typedef struct packed {
		lookup_result_t res;
		int unsigned    issued;
	} pending_t;

	logic           clk;
	logic           reset;
	lookup_req_t    lookup;
	logic           gc_start;
	lookup_result_t result;
	logic           gc_done;

	// Reference table and way counter
	entry_t         model_mem [ASSOC_WAYS][TABLE_ROWS];
	int             model_ctr;
	pending_t       exp_q [$];
	int unsigned    cyc;
	string          test_name;
	logic [31:0]    lfsr_state;
	// Host list, 0 is A and 1 is B, 15 is never a source
	mac_t           host_mac [16];
	vlan_t          host_vlan [16];
	port_num_t      host_port [16];

	tb_clock u_clock (
		.clk   (clk),
		.reset (reset)
	);

	mac_table #(
		.TABLE_ROWS  (TABLE_ROWS),
		.ASSOC_WAYS  (ASSOC_WAYS),
		.PENDING_SIZE(PENDING_SIZE)
	) u_dut (
		.clk      (clk),
		.reset    (reset),
		.lookup   (lookup),
		.gc_start (gc_start),
		.result   (result),
		.gc_done  (gc_done)
	);

	////////////////////////////////////////
	// Random numbers

	// Taps 32, 22, 2, 1
	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v          = {v[62:0], fb};
		end
		return v;
	endfunction

	task automatic make_host(int i);
		host_mac[i]  = mac_t'(rand_bits(48));
		// Two VLANs so some lookups cross VLANs and miss
		host_vlan[i] = rand_bits(1) ? 12'h014 : 12'h00a;
		host_port[i] = port_num_t'(rand_bits(5));
	endtask

	////////////////////////////////////////
	// Reference model

	function automatic int row_of(mac_t mac, vlan_t vlan);
		return int'(mac_hash(mac, vlan)) % TABLE_ROWS;
	endfunction

	// Expected answer, then learn and refresh side effects
	// Stale marks a source read that ran before its own earlier learn landed
	function automatic lookup_result_t ref_lookup(lookup_req_t req, bit stale);
		lookup_result_t r;
		int             drow;
		int             srow;
		int             hit_way;
		bit             src_found;
		r         = '0;
		r.done    = 1'b1;
		drow      = row_of(req.dst_mac, req.vlan);
		srow      = row_of(req.src_mac, req.vlan);
		hit_way   = -1;
		src_found = 1'b0;
		for (int w = 0; w < ASSOC_WAYS; w++) begin
			if (model_mem[w][drow].valid && model_mem[w][drow].vlan == req.vlan
				&& model_mem[w][drow].mac == req.dst_mac)
				hit_way = w;
			if (model_mem[w][srow].valid && model_mem[w][srow].vlan == req.vlan
				&& model_mem[w][srow].mac == req.src_mac)
				src_found = 1'b1;
		end
		if (hit_way >= 0) begin
			r.hit  = 1'b1;
			r.port = model_mem[hit_way][drow].port;
			// Refresh lands before the learn write
			model_mem[hit_way][drow].gc_mark = 1'b1;
		end
		if (!src_found) begin
			model_mem[model_ctr][srow] = '{1'b1, 1'b1, req.vlan, req.src_port, req.src_mac};
			model_ctr = (model_ctr + 1) % ASSOC_WAYS;
		end else if (stale) begin
			model_ctr = (model_ctr + 1) % ASSOC_WAYS;
		end
		return r;
	endfunction

	// Marked survives unmarked, unmarked is wiped
	function automatic void ref_gc();
		for (int w = 0; w < ASSOC_WAYS; w++)
			for (int r = 0; r < TABLE_ROWS; r++)
				if (model_mem[w][r].valid) begin
					if (model_mem[w][r].gc_mark)
						model_mem[w][r].gc_mark = 1'b0;
					else
						model_mem[w][r] = '0;
				end
	endfunction

	////////////////////////////////////////
	// Checks

	task automatic fail_now();
		$display("TB FAILED");
		$fatal(1, "run stopped at cycle %0d", cyc);
	endtask

	task automatic stop_run(string why);
		$display("%s", why);
		fail_now();
	endtask

	task automatic check_result(string name, lookup_result_t exp, lookup_result_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected done=%b hit=%b port=%0d, actual done=%b hit=%b port=%0d",
				name, exp.done, exp.hit, exp.port, act.done, act.hit, act.port);
			fail_now();
		end
	endtask

	// gc_done must pulse once within the sweep bound
	task automatic check_gc(string name);
		int waited;
		waited = 0;
		while (gc_done !== 1'b1) begin
			@(negedge clk);
			waited++;
			if (waited > GC_LIMIT)
				stop_run({name, ": garbage collection never signalled completion"});
		end
		@(negedge clk);
		if (gc_done !== 1'b0)
			stop_run({name, ": completion pulse lasted more than one cycle"});
	endtask

	// Cycle count and overall limit
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc > LIMIT)
			stop_run("Timeout: the run went past its cycle limit");
	end

	// One expected result per done cycle, at fixed latency
	always @(negedge clk) begin : compare
		pending_t pe;
		if (!reset) begin
			if (result.done) begin
				if (exp_q.size() == 0)
					stop_run("Result done arrived with no lookup outstanding");
				pe = exp_q.pop_front();
				if (cyc != pe.issued + LATENCY)
					stop_run({test_name, ": result done came at the wrong cycle"});
				check_result(test_name, pe.res, result);
			end else if (exp_q.size() != 0 && cyc > exp_q[0].issued + LATENCY) begin
				stop_run({test_name, ": no result done 3 cycles after a lookup"});
			end
		end
	end

	////////////////////////////////////////
	// Stimulus

	// One lookup, driven for one cycle from a falling edge
	task automatic issue_lookup(int s, int d, bit stale);
		lookup_req_t req;
		pending_t    pe;
		req.en       = 1'b1;
		req.vlan     = host_vlan[s];
		req.src_mac  = host_mac[s];
		req.src_port = host_port[s];
		req.dst_mac  = host_mac[d];
		pe.res       = ref_lookup(req, stale);
		pe.issued    = cyc;
		exp_q.push_back(pe);
		lookup = req;
		@(negedge clk);
		lookup.en = 1'b0;
	endtask

	task automatic spaced_lookup(int s, int d);
		issue_lookup(s, d, 1'b0);
		repeat (SPACING - 1) @(negedge clk);
	endtask

	task automatic run_gc(string name);
		gc_start = 1'b1;
		@(negedge clk);
		gc_start = 1'b0;
		ref_gc();
		check_gc(name);
		repeat (4) @(negedge clk);
	endtask

	initial begin
		lookup     = '0;
		gc_start   = 1'b0;
		cyc        = 0;
		model_ctr  = 0;
		lfsr_state = 32'h20a4;
		test_name  = "reset";
		for (int w = 0; w < ASSOC_WAYS; w++)
			for (int r = 0; r < TABLE_ROWS; r++)
				model_mem[w][r] = '0;
		for (int i = 0; i < 16; i++)
			make_host(i);
		// Hosts of the directed GC, refresh and dedup steps share A's VLAN
		host_vlan[0]  = 12'h00a;
		host_vlan[1]  = 12'h00a;
		host_vlan[2]  = 12'h00a;
		host_vlan[3]  = 12'h00a;
		host_vlan[14] = 12'h00a;
		@(negedge clk);
		while (reset)
			@(negedge clk);
		// RAM clear sweep
		repeat (20) @(negedge clk);

		test_name = "unknown_dst";
		spaced_lookup(0, 15);

		test_name = "learn_pair";
		spaced_lookup(0, 1);
		spaced_lookup(1, 0);
		test_name = "learn_random";
		for (int i = 2; i < 14; i++)
			spaced_lookup(i, int'(rand_bits(4)) % i);

		// Relearn A if an overwrite took it, then a burst
		test_name = "back_to_back";
		spaced_lookup(0, 1);
		for (int i = 0; i < 8; i++)
			issue_lookup(0, 1 + i, 1'b0);
		repeat (SPACING) @(negedge clk);

		test_name = "gc_mark_sweep";
		spaced_lookup(3, 0);
		run_gc("gc_first");
		spaced_lookup(0, 3);
		run_gc("gc_second");
		run_gc("gc_third");
		spaced_lookup(0, 3);

		test_name = "refresh";
		spaced_lookup(1, 0);
		spaced_lookup(2, 0);
		run_gc("gc_unmark");
		spaced_lookup(0, 1);
		run_gc("gc_after_refresh");
		spaced_lookup(0, 1);
		spaced_lookup(0, 2);

		// Second source read runs before the first learn lands
		test_name = "dedup";
		issue_lookup(14, 0, 1'b0);
		issue_lookup(14, 0, 1'b1);
		repeat (SPACING) @(negedge clk);
		spaced_lookup(0, 14);
		spaced_lookup(1, 0);

		repeat (LATENCY + 2) @(negedge clk);
		if (exp_q.size() != 0) begin
			stop_run("Lookups left without a result at the end");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);
	// 10 ns period
	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Reset held for 8 rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- source/mac_table.sv
`timescale 1ns/1ps

module mac_table
	import mac_table_pkg::*;
#(
	parameter int TABLE_ROWS   = 16,
	parameter int ASSOC_WAYS   = 4,
	parameter int PENDING_SIZE = 4,
	localparam int ROW_BITS = $clog2(TABLE_ROWS)
) (
	input  logic           clk,
	input  logic           reset,
	input  lookup_req_t    lookup,
	input  logic           gc_start,
	output lookup_result_t result,
	output logic           gc_done
);
	// Port A
	logic                  a_en;
	logic [ROW_BITS-1:0]   a_row;
	entry_t                a_data [ASSOC_WAYS];
	// Port B requests and grants
	table_req_t            src_req;
	table_req_t            learn_req;
	table_req_t            refresh_req;
	table_req_t            gc_req;
	logic                  learn_grant;
	logic                  refresh_grant;
	logic                  gc_grant;
	// Shared port B command and read data
	logic                  b_en;
	logic [ASSOC_WAYS-1:0] b_we;
	logic [15:0]           b_row;
	entry_t                b_wdata;
	entry_t                b_data [ASSOC_WAYS];
	entry_t                miss;

	////////////////////////////////////////
	// Way memories

	for (genvar w = 0; w < ASSOC_WAYS; w++) begin : g_way
		table_ram #(
			.TABLE_ROWS(TABLE_ROWS)
		) u_ram (
			.clk        (clk),
			.reset      (reset),
			.a_en       (a_en),
			.a_row      (a_row),
			.a_data     (a_data[w]),
			.b_en       (b_en),
			.b_we       (b_we[w]),
			.b_row      (b_row[ROW_BITS-1:0]),
			.b_data     (b_wdata),
			.b_data_out (b_data[w])
		);
	end

	////////////////////////////////////////
	// Port B peers and arbiter

	lookup_pipe #(
		.TABLE_ROWS(TABLE_ROWS),
		.ASSOC_WAYS(ASSOC_WAYS)
	) u_lookup (
		.clk           (clk),
		.reset         (reset),
		.lookup        (lookup),
		.a_en          (a_en),
		.a_row         (a_row),
		.a_data        (a_data),
		.src_req       (src_req),
		.b_data        (b_data),
		.refresh_req   (refresh_req),
		.refresh_grant (refresh_grant),
		.miss          (miss),
		.result        (result)
	);

	learn_queue #(
		.TABLE_ROWS  (TABLE_ROWS),
		.ASSOC_WAYS  (ASSOC_WAYS),
		.PENDING_SIZE(PENDING_SIZE)
	) u_learn (
		.clk    (clk),
		.reset  (reset),
		.miss   (miss),
		.grant  (learn_grant),
		.wr_req (learn_req)
	);

	gc_engine #(
		.TABLE_ROWS(TABLE_ROWS),
		.ASSOC_WAYS(ASSOC_WAYS)
	) u_gc (
		.clk      (clk),
		.reset    (reset),
		.gc_start (gc_start),
		.b_data   (b_data),
		.grant    (gc_grant),
		.req      (gc_req),
		.gc_done  (gc_done)
	);

	// Source read is never refused, so its grant has no listener
	table_port_arbiter #(
		.ASSOC_WAYS(ASSOC_WAYS)
	) u_arb (
		.clk           (clk),
		.src_req       (src_req),
		.learn_req     (learn_req),
		.refresh_req   (refresh_req),
		.gc_req        (gc_req),
		.src_grant     (),
		.learn_grant   (learn_grant),
		.refresh_grant (refresh_grant),
		.gc_grant      (gc_grant),
		.b_en          (b_en),
		.b_we          (b_we),
		.b_row         (b_row),
		.b_data        (b_wdata)
	);

endmodule

//--- source/table_port_arbiter.sv
`timescale 1ns/1ps

module table_port_arbiter
	import mac_table_pkg::*;
#(
	parameter int ASSOC_WAYS = 4,
	localparam int WAY_BITS = (ASSOC_WAYS > 1) ? $clog2(ASSOC_WAYS) : 1
) (
	input  logic                  clk,
	input  table_req_t            src_req,
	input  table_req_t            learn_req,
	input  table_req_t            refresh_req,
	input  table_req_t            gc_req,
	output logic                  src_grant,
	output logic                  learn_grant,
	output logic                  refresh_grant,
	output logic                  gc_grant,
	output logic                  b_en,
	output logic [ASSOC_WAYS-1:0] b_we,
	output logic [15:0]           b_row,
	output entry_t                b_data
);
	table_req_t sel;

	////////////////////////////////////////
	// Fixed priority select

	// Source read, learn, refresh, then GC
	always_comb begin
		src_grant     = 1'b0;
		learn_grant   = 1'b0;
		refresh_grant = 1'b0;
		gc_grant      = 1'b0;
		sel           = '0;
		if (src_req.req) begin
			src_grant = 1'b1;
			sel       = src_req;
		end else if (learn_req.req) begin
			learn_grant = 1'b1;
			sel         = learn_req;
		end else if (refresh_req.req) begin
			refresh_grant = 1'b1;
			sel           = refresh_req;
		end else if (gc_req.req) begin
			gc_grant = 1'b1;
			sel      = gc_req;
		end
	end

	// Shared command to all ways
	// Write enable only to the addressed way
	always_comb begin
		b_en   = sel.req;
		b_row  = sel.row;
		b_data = sel.data;
		b_we   = '0;
		if (sel.req && sel.we)
			b_we[sel.way[WAY_BITS-1:0]] = 1'b1;
	end

	assert property (@(posedge clk)
		$onehot0({src_grant, learn_grant, refresh_grant, gc_grant}));

	// Lookups are never stalled on port B
	assert property (@(posedge clk) src_grant == src_req.req);

endmodule

//--- source/gc_engine.sv
`timescale 1ns/1ps

module gc_engine
	import mac_table_pkg::*;
#(
	parameter int TABLE_ROWS = 16,
	parameter int ASSOC_WAYS = 4,
	localparam int ROW_BITS = $clog2(TABLE_ROWS),
	localparam int WAY_BITS = (ASSOC_WAYS > 1) ? $clog2(ASSOC_WAYS) : 1
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       gc_start,
	input  entry_t     b_data [ASSOC_WAYS],
	input  logic       grant,
	output table_req_t req,
	output logic       gc_done
);
	typedef enum logic [2:0] {
		GC_IDLE,
		GC_READ,
		GC_READ_WAIT,
		GC_DECIDE,
		GC_WRITE,
		GC_NEXT
	} gc_state_t;

	gc_state_t           state;
	logic [ROW_BITS-1:0] row;
	logic [WAY_BITS-1:0] way;
	entry_t              rdata;
	entry_t              wdata;

	// Read data lands in DECIDE
	assign rdata = b_data[way];

	always_comb begin
		req      = '0;
		req.req  = (state == GC_READ) || (state == GC_WRITE);
		req.we   = (state == GC_WRITE);
		req.row  = 16'(row);
		req.way  = 4'(way);
		req.data = wdata;
	end

	////////////////////////////////////////
	// Sweep FSM over way then row

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= GC_IDLE;
			row     <= '0;
			way     <= '0;
			gc_done <= 1'b0;
		end else begin
			gc_done <= 1'b0;
			case (state)
				GC_IDLE: begin
					if (gc_start) begin
						row   <= '0;
						way   <= '0;
						state <= GC_READ;
					end
				end
				GC_READ: begin
					if (grant)
						state <= GC_READ_WAIT;
				end
				GC_READ_WAIT: state <= GC_DECIDE;
				// Invalid entries need no write
				GC_DECIDE: state <= rdata.valid ? GC_WRITE : GC_NEXT;
				GC_WRITE: begin
					if (grant)
						state <= GC_NEXT;
				end
				GC_NEXT: begin
					if (row == ROW_BITS'(TABLE_ROWS - 1)) begin
						row <= '0;
						if (way == WAY_BITS'(ASSOC_WAYS - 1)) begin
							gc_done <= 1'b1;
							state   <= GC_IDLE;
						end else begin
							way   <= way + 1'b1;
							state <= GC_READ;
						end
					end else begin
						row   <= row + 1'b1;
						state <= GC_READ;
					end
				end
				default: state <= GC_IDLE;
			endcase
		end
	end

	// Marked entry keeps its data unmarked
	// Unmarked entry is wiped
	always_ff @(posedge clk) begin
		if (state == GC_DECIDE) begin
			wdata <= '0;
			if (rdata.gc_mark) begin
				wdata         <= rdata;
				wdata.gc_mark <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		state inside {GC_IDLE, GC_READ, GC_READ_WAIT, GC_DECIDE, GC_WRITE, GC_NEXT});

endmodule

//--- source/learn_queue.sv
`timescale 1ns/1ps

module learn_queue
	import mac_table_pkg::*;
#(
	parameter int TABLE_ROWS   = 16,
	parameter int ASSOC_WAYS   = 4,
	parameter int PENDING_SIZE = 4,
	localparam int ROW_BITS  = $clog2(TABLE_ROWS),
	localparam int WAY_BITS  = (ASSOC_WAYS > 1) ? $clog2(ASSOC_WAYS) : 1,
	localparam int PEND_BITS = (PENDING_SIZE > 1) ? $clog2(PENDING_SIZE) : 1
) (
	input  logic       clk,
	input  logic       reset,
	input  entry_t     miss,
	input  logic       grant,
	output table_req_t wr_req
);
	logic [PENDING_SIZE-1:0] slot_valid;
	entry_t                  slot_data [PENDING_SIZE];
	logic [WAY_BITS-1:0]     slot_way [PENDING_SIZE];
	logic [WAY_BITS-1:0]     way_ctr;
	logic                    pop_busy;
	logic [PEND_BITS-1:0]    pop_slot;
	logic                    dup;
	logic                    free_found;
	logic [PEND_BITS-1:0]    free_slot;
	logic                    pop_found;
	logic [PEND_BITS-1:0]    pop_next;
	logic                    do_insert;
	logic [15:0]             wr_hash;

	////////////////////////////////////////
	// Slot scan

	// Walk downward so the lowest slot wins
	always_comb begin
		dup        = 1'b0;
		free_found = 1'b0;
		free_slot  = '0;
		pop_found  = 1'b0;
		pop_next   = '0;
		for (int i = PENDING_SIZE - 1; i >= 0; i--) begin
			if (slot_valid[i] && (slot_data[i].mac == miss.mac)
				&& (slot_data[i].vlan == miss.vlan) && (slot_data[i].port == miss.port))
				dup = 1'b1;
			if (!slot_valid[i]) begin
				free_found = 1'b1;
				free_slot  = PEND_BITS'(i);
			end else begin
				pop_found = 1'b1;
				pop_next  = PEND_BITS'(i);
			end
		end
	end

	// Full set drops the address
	assign do_insert = miss.valid && !dup && free_found;

	////////////////////////////////////////
	// Insert and pop

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= '0;
			way_ctr    <= '0;
			pop_busy   <= 1'b0;
			pop_slot   <= '0;
		end else begin
			// Way counter steps on every miss, duplicates included
			if (miss.valid)
				way_ctr <= (way_ctr == WAY_BITS'(ASSOC_WAYS - 1)) ? '0 : way_ctr + 1'b1;
			if (do_insert)
				slot_valid[free_slot] <= 1'b1;
			// Active slot stays fixed until its write lands
			if (pop_busy && grant) begin
				slot_valid[pop_slot] <= 1'b0;
				pop_busy             <= 1'b0;
			end else if (!pop_busy && pop_found) begin
				pop_busy <= 1'b1;
				pop_slot <= pop_next;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_insert) begin
			slot_data[free_slot] <= miss;
			slot_way[free_slot]  <= way_ctr;
		end
	end

	// Table write with mark and valid set
	assign wr_hash = mac_hash(slot_data[pop_slot].mac, slot_data[pop_slot].vlan);

	always_comb begin
		wr_req              = '0;
		wr_req.req          = pop_busy;
		wr_req.we           = 1'b1;
		wr_req.row          = 16'(wr_hash[ROW_BITS-1:0]);
		wr_req.way          = 4'(slot_way[pop_slot]);
		wr_req.data         = slot_data[pop_slot];
		wr_req.data.gc_mark = 1'b1;
		wr_req.data.valid   = 1'b1;
	end

	// Arbiter only grants a live request
	assert property (@(posedge clk) disable iff (reset) grant |-> wr_req.req);

endmodule

//--- source/lookup_pipe.sv
`timescale 1ns/1ps

module lookup_pipe
	import mac_table_pkg::*;
#(
	parameter int TABLE_ROWS = 16,
	parameter int ASSOC_WAYS = 4,
	localparam int ROW_BITS = $clog2(TABLE_ROWS),
	localparam int WAY_BITS = (ASSOC_WAYS > 1) ? $clog2(ASSOC_WAYS) : 1
) (
	input  logic                clk,
	input  logic                reset,
	input  lookup_req_t         lookup,
	output logic                a_en,
	output logic [ROW_BITS-1:0] a_row,
	input  entry_t              a_data [ASSOC_WAYS],
	output table_req_t          src_req,
	input  entry_t              b_data [ASSOC_WAYS],
	output table_req_t          refresh_req,
	input  logic                refresh_grant,
	output entry_t              miss,
	output lookup_result_t      result
);
	logic [15:0]           dst_hash;
	logic [15:0]           src_hash;
	lookup_req_t           pkt_q1;
	lookup_req_t           pkt_q2;
	logic [ROW_BITS-1:0]   row_q1;
	logic [ROW_BITS-1:0]   row_q2;
	logic [ASSOC_WAYS-1:0] dst_match;
	logic [ASSOC_WAYS-1:0] src_match;
	logic [WAY_BITS-1:0]   dst_way;
	entry_t                dst_entry;
	logic                  dst_hit;
	logic                  need_refresh;

	////////////////////////////////////////
	// Issue both reads

	assign dst_hash = mac_hash(lookup.dst_mac, lookup.vlan);
	assign src_hash = mac_hash(lookup.src_mac, lookup.vlan);
	// Destination on port A
	assign a_en  = lookup.en;
	assign a_row = dst_hash[ROW_BITS-1:0];

	// Source on port B at top priority
	always_comb begin
		src_req     = '0;
		src_req.req = lookup.en;
		src_req.row = 16'(src_hash[ROW_BITS-1:0]);
	end

	// Match RAM latency
	always_ff @(posedge clk) begin
		pkt_q1 <= lookup;
		pkt_q2 <= pkt_q1;
		row_q1 <= a_row;
		row_q2 <= row_q1;
		if (reset) begin
			pkt_q1.en <= 1'b0;
			pkt_q2.en <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Way compare

	always_comb begin
		for (int i = 0; i < ASSOC_WAYS; i++) begin
			dst_match[i] = a_data[i].valid && (a_data[i].vlan == pkt_q2.vlan)
				&& (a_data[i].mac == pkt_q2.dst_mac);
			src_match[i] = b_data[i].valid && (b_data[i].vlan == pkt_q2.vlan)
				&& (b_data[i].mac == pkt_q2.src_mac);
		end
	end

	// Highest matching way wins
	always_comb begin
		dst_way = '0;
		for (int i = 0; i < ASSOC_WAYS; i++) begin
			if (dst_match[i])
				dst_way = WAY_BITS'(i);
		end
	end

	assign dst_entry    = a_data[dst_way];
	assign dst_hit      = pkt_q2.en && (|dst_match);
	assign need_refresh = dst_hit && !dst_entry.gc_mark;

	// Result and learn candidate
	always_ff @(posedge clk) begin
		result.done  <= pkt_q2.en;
		result.hit   <= dst_hit;
		result.port  <= dst_hit ? dst_entry.port : '0;
		miss.gc_mark <= 1'b0;
		miss.valid   <= pkt_q2.en && !(|src_match);
		miss.vlan    <= pkt_q2.vlan;
		miss.port    <= pkt_q2.src_port;
		miss.mac     <= pkt_q2.src_mac;
		if (reset) begin
			result.done <= 1'b0;
			result.hit  <= 1'b0;
			miss.valid  <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Mark refresh

	// Newer refresh overwrites one still waiting
	always_ff @(posedge clk) begin
		if (refresh_grant)
			refresh_req.req <= 1'b0;
		if (need_refresh) begin
			refresh_req.req          <= 1'b1;
			refresh_req.we           <= 1'b1;
			refresh_req.row          <= 16'(row_q2);
			refresh_req.way          <= 4'(dst_way);
			refresh_req.data         <= dst_entry;
			refresh_req.data.gc_mark <= 1'b1;
		end
		if (reset)
			refresh_req.req <= 1'b0;
	end

	// Learning and GC never leave a duplicate in one row
	assert property (@(posedge clk) disable iff (reset)
		pkt_q2.en |-> $onehot0(dst_match));

endmodule

//--- source/table_ram.sv
`timescale 1ns/1ps

module table_ram
	import mac_table_pkg::*;
#(
	parameter int TABLE_ROWS = 16,
	localparam int ROW_BITS = $clog2(TABLE_ROWS)
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                a_en,
	input  logic [ROW_BITS-1:0] a_row,
	output entry_t              a_data,
	input  logic                b_en,
	input  logic                b_we,
	input  logic [ROW_BITS-1:0] b_row,
	input  entry_t              b_data,
	output entry_t              b_data_out
);
	entry_t              mem [TABLE_ROWS];
	entry_t              a_q1;
	entry_t              b_q1;
	logic                clearing;
	logic [ROW_BITS-1:0] clear_row;

	////////////////////////////////////////
	// Clear sweep after reset

	always_ff @(posedge clk) begin
		if (reset) begin
			clearing  <= 1'b1;
			clear_row <= '0;
		end else if (clearing) begin
			clear_row <= clear_row + 1'b1;
			// Last row zeroed this cycle
			if (clear_row == ROW_BITS'(TABLE_ROWS - 1))
				clearing <= 1'b0;
		end
	end

	// Sweep owns the write path until done
	always_ff @(posedge clk) begin
		if (clearing)
			mem[clear_row] <= '0;
		else if (b_en && b_we)
			mem[b_row] <= b_data;
	end

	////////////////////////////////////////
	// Two-stage registered reads

	always_ff @(posedge clk) begin
		if (a_en)
			a_q1 <= mem[a_row];
		a_data <= a_q1;
		// Port B reads old data on a same-row write
		if (b_en)
			b_q1 <= mem[b_row];
		b_data_out <= b_q1;
	end

endmodule

//--- source/mac_table_pkg.sv
package mac_table_pkg;

	////////////////////////////////////////
	// Field widths and base types

	localparam int MAC_WIDTH  = 48;
	localparam int VLAN_WIDTH = 12;
	localparam int PORT_WIDTH = 5;

	typedef logic [MAC_WIDTH-1:0]  mac_t;
	typedef logic [VLAN_WIDTH-1:0] vlan_t;
	typedef logic [PORT_WIDTH-1:0] port_num_t;

	////////////////////////////////////////
	// Table entry and request formats

	// One stored address
	typedef struct packed {
		logic      gc_mark;
		logic      valid;
		vlan_t     vlan;
		port_num_t port;
		mac_t      mac;
	} entry_t;

	// Incoming packet header
	typedef struct packed {
		logic      en;
		vlan_t     vlan;
		mac_t      src_mac;
		port_num_t src_port;
		mac_t      dst_mac;
	} lookup_req_t;

	typedef struct packed {
		logic      done;
		logic      hit;
		port_num_t port;
	} lookup_result_t;

	// Port B command from one requester
	// Row and way sized for the largest table
	typedef struct packed {
		logic        req;
		logic        we;
		logic [15:0] row;
		logic [3:0]  way;
		entry_t      data;
	} table_req_t;

	// XOR fold of the address with the VLAN
	function automatic logic [15:0] mac_hash(mac_t mac, vlan_t vlan);
		return mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ 16'(vlan);
	endfunction

endpackage
